/* source/issue_params.svh */
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// ------------------------------
// field widths
`define WORD_W      32
`define GPR_W       5
`define EXC_W       5
`define LINK_REG    5'd31   // ra, written by the link forms

// ------------------------------
// major opcodes, inst[31:26]
`define OP_SPECIAL  6'h00
`define OP_REGIMM   6'h01
`define OP_J        6'h02
`define OP_JAL      6'h03
`define OP_BEQ      6'h04
`define OP_BNE      6'h05
`define OP_BLEZ     6'h06
`define OP_BGTZ     6'h07
`define OP_ADDIU    6'h09
`define OP_SLTI     6'h0a
`define OP_SLTIU    6'h0b
`define OP_ANDI     6'h0c
`define OP_ORI      6'h0d
`define OP_XORI     6'h0e
`define OP_LUI      6'h0f
`define OP_LW       6'h23
`define OP_SW       6'h2b

// ------------------------------
// SPECIAL funct codes, inst[5:0]
`define FN_SLL      6'h00
`define FN_SRL      6'h02
`define FN_SRA      6'h03
`define FN_JR       6'h08
`define FN_JALR     6'h09
`define FN_MFHI     6'h10
`define FN_MFLO     6'h12
`define FN_MULT     6'h18
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_XOR      6'h26
`define FN_NOR      6'h27
`define FN_SLT      6'h2a
`define FN_SLTU     6'h2b

// REGIMM selects, inst[20:16]
`define RI_BLTZ     5'h00
`define RI_BGEZ     5'h01
`define RI_BLTZAL   5'h10
`define RI_BGEZAL   5'h11

`endif

/* source/issuePkg.sv */
`include "issue_params.svh"

package issuePkg;

    typedef enum logic [1:0] {
        noIssue     = 2'd0,
        singleIssue = 2'd1,
        dualIssue   = 2'd2
    } issueMode_t;

    // bit 0 -> may sit in slot zero, bit 1 -> may sit in slot one
    typedef logic [1:0] slotMask_t;

    // one queue entry as handed over by fetch, 103 bits
    typedef struct packed {
        logic [`WORD_W-1:0] pc;
        logic [`WORD_W-1:0] inst;
        logic               hasExc;
        logic [`EXC_W-1:0]  excCode;
        logic               predTake;
        logic [`WORD_W-1:0] predDest;
    } fetchInfo_t;

    // register numbers are zero whenever their need bit is low
    typedef struct packed {
        logic [`GPR_W-1:0] rsNum;
        logic [`GPR_W-1:0] rtNum;
        logic [`GPR_W-1:0] wrNum;
        logic              needRs;
        logic              needRt;
        logic              needWr;
    } regUse_t;

endpackage

/* source/regUseDecoder.sv */
`timescale 1ns/1ps
`include "issue_params.svh"

module regUseDecoder (
    input  logic [`WORD_W-1:0]   inst_i,
    output issuePkg::regUse_t    regUse_o,
    output issuePkg::slotMask_t  slotMask_o
);

    logic [5:0]        opcode;
    logic [5:0]        funct;
    logic [`GPR_W-1:0] rsField;
    logic [`GPR_W-1:0] rtField;
    logic [`GPR_W-1:0] rdField;

    logic              needRs;
    logic              needRt;
    logic              needWr;
    logic [`GPR_W-1:0] wrNum;
    logic              isBranch;   // branch or jump, slot zero only

    assign opcode  = inst_i[31:26];
    assign funct   = inst_i[5:0];
    assign rsField = inst_i[25:21];
    assign rtField = inst_i[20:16];
    assign rdField = inst_i[15:11];

    always_comb begin
        needRs   = 1'b0;
        needRt   = 1'b0;
        needWr   = 1'b0;
        wrNum    = rdField;
        isBranch = 1'b0;
        case (opcode)
            `OP_SPECIAL: begin
                case (funct)
                    `FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR,
                    `FN_NOR, `FN_SLT, `FN_SLTU: begin
                        needRs = 1'b1;
                        needRt = 1'b1;
                        needWr = 1'b1;
                    end
                    `FN_SLL, `FN_SRL, `FN_SRA: begin   // shamt form, rs unused
                        needRt = 1'b1;
                        needWr = 1'b1;
                    end
                    `FN_JR: begin
                        needRs   = 1'b1;
                        isBranch = 1'b1;
                    end
                    `FN_JALR: begin
                        needRs   = 1'b1;
                        needWr   = 1'b1;
                        isBranch = 1'b1;
                    end
                    `FN_MULT: begin   // result goes to hi/lo
                        needRs = 1'b1;
                        needRt = 1'b1;
                    end
                    `FN_MFHI, `FN_MFLO: begin
                        needWr = 1'b1;
                    end
                    default: ;
                endcase
            end
            `OP_REGIMM: begin
                case (rtField)
                    `RI_BLTZ, `RI_BGEZ: begin
                        needRs   = 1'b1;
                        isBranch = 1'b1;
                    end
                    `RI_BLTZAL, `RI_BGEZAL: begin
                        needRs   = 1'b1;
                        needWr   = 1'b1;
                        wrNum    = `LINK_REG;
                        isBranch = 1'b1;
                    end
                    default: ;
                endcase
            end
            `OP_J: begin
                isBranch = 1'b1;
            end
            `OP_JAL: begin
                needWr   = 1'b1;
                wrNum    = `LINK_REG;
                isBranch = 1'b1;
            end
            `OP_BEQ, `OP_BNE: begin
                needRs   = 1'b1;
                needRt   = 1'b1;
                isBranch = 1'b1;
            end
            `OP_BLEZ, `OP_BGTZ: begin
                needRs   = 1'b1;
                isBranch = 1'b1;
            end
            `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI,
            `OP_ORI, `OP_XORI, `OP_LW: begin
                needRs = 1'b1;
                needWr = 1'b1;
                wrNum  = rtField;
            end
            `OP_LUI: begin
                needWr = 1'b1;
                wrNum  = rtField;
            end
            `OP_SW: begin
                needRs = 1'b1;
                needRt = 1'b1;
            end
            default: ;   // unknown, no register use
        endcase
    end

    // numbers without a need bit go out as zero
    assign regUse_o = '{
        rsNum:  needRs ? rsField : '0,
        rtNum:  needRt ? rtField : '0,
        wrNum:  needWr ? wrNum   : '0,
        needRs: needRs,
        needRt: needRt,
        needWr: needWr
    };

    assign slotMask_o = isBranch ? 2'b01 : 2'b11;

endmodule

/* source/issueRule.sv */
`timescale 1ns/1ps

module issueRule (
    input  logic                 clk,
    input  logic                 rstN_i,
    input  logic [1:0]           supplyValid_i,
    input  issuePkg::regUse_t    regUse0_i,
    input  issuePkg::regUse_t    regUse1_i,
    input  issuePkg::slotMask_t  slotMask0_i,
    input  issuePkg::slotMask_t  slotMask1_i,
    input  logic                 hasExc0_i,
    output logic                 copySlotZero_o,
    output issuePkg::issueMode_t issueMode_o
);

    logic                 slot0Ok;
    logic                 slot1Ok;
    logic                 rawHazard;
    issuePkg::issueMode_t nextMode;

    // ------------------------------
    // slot rules
    assign slot0Ok = slotMask0_i[0] | hasExc0_i;   // excepting inst lifts slot 0 limit
    assign slot1Ok = slotMask1_i[1];

    // newer inst reads what the older one writes, r0 included
    assign rawHazard = regUse0_i.needWr &
                       ((regUse1_i.needRs & (regUse1_i.rsNum == regUse0_i.wrNum)) |
                        (regUse1_i.needRt & (regUse1_i.rtNum == regUse0_i.wrNum)));

    always_comb begin
        if (supplyValid_i[1]) begin
            if (slot0Ok && slot1Ok && !rawHazard) begin
                nextMode = issuePkg::dualIssue;
            end else begin
                nextMode = issuePkg::singleIssue;
            end
        end else if (supplyValid_i[0]) begin
            // alone it still has to wait for its delay slot
            nextMode = slotMask0_i[1] ? issuePkg::singleIssue : issuePkg::noIssue;
        end else begin
            nextMode = issuePkg::noIssue;
        end
    end

    assign copySlotZero_o = (nextMode == issuePkg::singleIssue);

    // ------------------------------
    // issue latch
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            issueMode_o <= issuePkg::noIssue;
        end else begin
            issueMode_o <= nextMode;
        end
    end

endmodule

/* source/slotSteer.sv */
`timescale 1ns/1ps

module slotSteer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rstN_i,
    input  payload_t entry0_i,
    input  payload_t entry1_i,
    input  logic     copySlotZero_i,
    output payload_t slot0_o,
    output payload_t slot1_o
);

    payload_t slot1Next;

    // single issue mirrors the older entry into slot 1
    assign slot1Next = copySlotZero_i ? entry0_i : entry1_i;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            slot0_o <= '0;
            slot1_o <= '0;
        end else begin
            slot0_o <= entry0_i;   // older entry always lands in slot 0
            slot1_o <= slot1Next;
        end
    end

endmodule

/* source/dualIssueArbiter.sv */
`timescale 1ns/1ps
`include "issue_params.svh"

module dualIssueArbiter (
    input  logic                 clk,
    input  logic                 rstN_i,
    input  logic [1:0]           supplyValid_i,

    input  logic [`WORD_W-1:0]   pcEntry0_i,
    input  logic [`WORD_W-1:0]   instEntry0_i,
    input  logic                 hasExcEntry0_i,
    input  logic [`EXC_W-1:0]    excCodeEntry0_i,
    input  logic                 predTakeEntry0_i,
    input  logic [`WORD_W-1:0]   predDestEntry0_i,

    input  logic [`WORD_W-1:0]   pcEntry1_i,
    input  logic [`WORD_W-1:0]   instEntry1_i,
    input  logic                 hasExcEntry1_i,
    input  logic [`EXC_W-1:0]    excCodeEntry1_i,
    input  logic                 predTakeEntry1_i,
    input  logic [`WORD_W-1:0]   predDestEntry1_i,

    output issuePkg::issueMode_t issueMode_o,

    output logic [`WORD_W-1:0]   pcSlot0_o,
    output logic [`WORD_W-1:0]   instSlot0_o,
    output logic                 hasExcSlot0_o,
    output logic [`EXC_W-1:0]    excCodeSlot0_o,
    output logic                 predTakeSlot0_o,
    output logic [`WORD_W-1:0]   predDestSlot0_o,
    output issuePkg::regUse_t    regUseSlot0_o,

    output logic [`WORD_W-1:0]   pcSlot1_o,
    output logic [`WORD_W-1:0]   instSlot1_o,
    output logic                 hasExcSlot1_o,
    output logic [`EXC_W-1:0]    excCodeSlot1_o,
    output logic                 predTakeSlot1_o,
    output logic [`WORD_W-1:0]   predDestSlot1_o,
    output issuePkg::regUse_t    regUseSlot1_o
);

    issuePkg::fetchInfo_t entry0;
    issuePkg::fetchInfo_t entry1;
    issuePkg::fetchInfo_t slot0;
    issuePkg::fetchInfo_t slot1;
    issuePkg::regUse_t    use0;
    issuePkg::regUse_t    use1;
    issuePkg::slotMask_t  mask0;
    issuePkg::slotMask_t  mask1;
    logic                 copySlotZero;

    // ------------------------------
    // pack queue entries
    assign entry0 = '{pc: pcEntry0_i, inst: instEntry0_i, hasExc: hasExcEntry0_i,
                      excCode: excCodeEntry0_i, predTake: predTakeEntry0_i,
                      predDest: predDestEntry0_i};
    assign entry1 = '{pc: pcEntry1_i, inst: instEntry1_i, hasExc: hasExcEntry1_i,
                      excCode: excCodeEntry1_i, predTake: predTakeEntry1_i,
                      predDest: predDestEntry1_i};

    regUseDecoder decoder0 (
        .inst_i     (instEntry0_i),
        .regUse_o   (use0),
        .slotMask_o (mask0)
    );

    regUseDecoder decoder1 (
        .inst_i     (instEntry1_i),
        .regUse_o   (use1),
        .slotMask_o (mask1)
    );

    issueRule rule0 (
        .clk            (clk),
        .rstN_i         (rstN_i),
        .supplyValid_i  (supplyValid_i),
        .regUse0_i      (use0),
        .regUse1_i      (use1),
        .slotMask0_i    (mask0),
        .slotMask1_i    (mask1),
        .hasExc0_i      (hasExcEntry0_i),
        .copySlotZero_o (copySlotZero),
        .issueMode_o    (issueMode_o)
    );

    // fetch payload and register use steered by the same choice
    slotSteer #(.payload_t(issuePkg::fetchInfo_t)) fetchSteer (
        .clk            (clk),
        .rstN_i         (rstN_i),
        .entry0_i       (entry0),
        .entry1_i       (entry1),
        .copySlotZero_i (copySlotZero),
        .slot0_o        (slot0),
        .slot1_o        (slot1)
    );

    slotSteer #(.payload_t(issuePkg::regUse_t)) useSteer (
        .clk            (clk),
        .rstN_i         (rstN_i),
        .entry0_i       (use0),
        .entry1_i       (use1),
        .copySlotZero_i (copySlotZero),
        .slot0_o        (regUseSlot0_o),
        .slot1_o        (regUseSlot1_o)
    );

    // ------------------------------
    // unpack issue slots
    assign pcSlot0_o       = slot0.pc;
    assign instSlot0_o     = slot0.inst;
    assign hasExcSlot0_o   = slot0.hasExc;
    assign excCodeSlot0_o  = slot0.excCode;
    assign predTakeSlot0_o = slot0.predTake;
    assign predDestSlot0_o = slot0.predDest;

    assign pcSlot1_o       = slot1.pc;
    assign instSlot1_o     = slot1.inst;
    assign hasExcSlot1_o   = slot1.hasExc;
    assign excCodeSlot1_o  = slot1.excCode;
    assign predTakeSlot1_o = slot1.predTake;
    assign predDestSlot1_o = slot1.predDest;

endmodule

/* verification/issueVectors.svh */
`ifndef ISSUE_VECTORS_SVH
`define ISSUE_VECTORS_SVH

// one row per cycle: supplyValid, inst0, inst1, hasExc0, mode, slot 0 use, slot 1 use
localparam int numRows = 30;

logic [1:0]           rowValid [numRows];
logic [31:0]          rowInst0 [numRows];
logic [31:0]          rowInst1 [numRows];
logic                 rowExc0  [numRows];
issuePkg::issueMode_t rowMode  [numRows];
issuePkg::regUse_t    rowUse0  [numRows];
issuePkg::regUse_t    rowUse1  [numRows];
int                   rowCount = 0;

task automatic addRow(input logic [1:0] sv, input logic [31:0] i0, input logic [31:0] i1,
                      input logic exc0, input issuePkg::issueMode_t mode,
                      input issuePkg::regUse_t u0, input issuePkg::regUse_t u1);
    rowValid[rowCount] = sv;
    rowInst0[rowCount] = i0;
    rowInst1[rowCount] = i1;
    rowExc0[rowCount]  = exc0;
    rowMode[rowCount]  = mode;
    rowUse0[rowCount]  = u0;
    rowUse1[rowCount]  = u1;
    rowCount++;
endtask

task automatic loadVectors();
    // independent ALU pair, then hazards
    addRow(2'b11, rType(1, 2, 3, 0, `FN_ADDU), iType(`OP_ORI, 4, 6), 0, modeDual,
           useOf(1, 2, 3, 1, 1, 1), useOf(4, 0, 6, 1, 0, 1));
    addRow(2'b11, rType(1, 2, 5, 0, `FN_ADDU), iType(`OP_SW, 7, 5), 0, modeSingle,
           useOf(1, 2, 5, 1, 1, 1), useOf(1, 2, 5, 1, 1, 1));
    addRow(2'b11, jType(`OP_JAL), rType(31, 0, 8, 0, `FN_ADDU), 0, modeSingle,
           useOf(0, 0, 31, 0, 0, 1), useOf(0, 0, 31, 0, 0, 1));
    // slot restriction
    addRow(2'b01, iType(`OP_BEQ, 1, 2), iType(`OP_LUI, 0, 9), 0, modeNone,
           useOf(1, 2, 0, 1, 1, 0), useOf(0, 0, 9, 0, 0, 1));
    addRow(2'b11, iType(`OP_BEQ, 1, 2), rType(3, 4, 10, 0, `FN_ADDU), 0, modeDual,
           useOf(1, 2, 0, 1, 1, 0), useOf(3, 4, 10, 1, 1, 1));
    addRow(2'b11, rType(1, 2, 11, 0, `FN_ADDU), iType(`OP_BNE, 3, 4), 0, modeSingle,
           useOf(1, 2, 11, 1, 1, 1), useOf(1, 2, 11, 1, 1, 1));
    addRow(2'b11, rType(12, 0, 0, 0, `FN_JR), iType(`OP_BEQ, 1, 2), 1, modeSingle,
           useOf(12, 0, 0, 1, 0, 0), useOf(12, 0, 0, 1, 0, 0));
    // decode coverage
    addRow(2'b11, rType(1, 2, 13, 0, `FN_SUBU), rType(3, 4, 14, 0, `FN_AND), 0, modeDual,
           useOf(1, 2, 13, 1, 1, 1), useOf(3, 4, 14, 1, 1, 1));
    addRow(2'b11, rType(1, 2, 15, 0, `FN_OR), rType(3, 4, 16, 0, `FN_XOR), 0, modeDual,
           useOf(1, 2, 15, 1, 1, 1), useOf(3, 4, 16, 1, 1, 1));
    addRow(2'b11, rType(1, 2, 17, 0, `FN_NOR), rType(3, 4, 18, 0, `FN_SLT), 0, modeDual,
           useOf(1, 2, 17, 1, 1, 1), useOf(3, 4, 18, 1, 1, 1));
    addRow(2'b11, rType(1, 2, 19, 0, `FN_SLTU), rType(7, 5, 20, 3, `FN_SLL), 0, modeDual,
           useOf(1, 2, 19, 1, 1, 1), useOf(0, 5, 20, 0, 1, 1));
    addRow(2'b11, rType(0, 6, 21, 2, `FN_SRL), rType(0, 7, 22, 1, `FN_SRA), 0, modeDual,
           useOf(0, 6, 21, 0, 1, 1), useOf(0, 7, 22, 0, 1, 1));
    addRow(2'b11, rType(1, 2, 0, 0, `FN_MULT), rType(0, 0, 23, 0, `FN_MFHI), 0, modeDual,
           useOf(1, 2, 0, 1, 1, 0), useOf(0, 0, 23, 0, 0, 1));
    addRow(2'b11, rType(0, 0, 24, 0, `FN_MFLO), iType(`OP_ADDIU, 1, 25), 0, modeDual,
           useOf(0, 0, 24, 0, 0, 1), useOf(1, 0, 25, 1, 0, 1));
    addRow(2'b11, iType(`OP_SLTI, 2, 26), iType(`OP_SLTIU, 3, 27), 0, modeDual,
           useOf(2, 0, 26, 1, 0, 1), useOf(3, 0, 27, 1, 0, 1));
    addRow(2'b11, iType(`OP_ANDI, 4, 28), iType(`OP_XORI, 5, 29), 0, modeDual,
           useOf(4, 0, 28, 1, 0, 1), useOf(5, 0, 29, 1, 0, 1));
    addRow(2'b11, iType(`OP_LUI, 0, 30), iType(`OP_LW, 8, 9), 0, modeDual,
           useOf(0, 0, 30, 0, 0, 1), useOf(8, 0, 9, 1, 0, 1));
    addRow(2'b11, rType(13, 0, 31, 0, `FN_JALR), rType(2, 3, 1, 0, `FN_ADDU), 0, modeDual,
           useOf(13, 0, 31, 1, 0, 1), useOf(2, 3, 1, 1, 1, 1));
    addRow(2'b11, iType(`OP_BLEZ, 4, 0), rType(5, 6, 2, 0, `FN_SUBU), 0, modeDual,
           useOf(4, 0, 0, 1, 0, 0), useOf(5, 6, 2, 1, 1, 1));
    addRow(2'b11, iType(`OP_BGTZ, 7, 0), rType(8, 9, 3, 0, `FN_OR), 0, modeDual,
           useOf(7, 0, 0, 1, 0, 0), useOf(8, 9, 3, 1, 1, 1));
    addRow(2'b11, iType(`OP_REGIMM, 10, `RI_BLTZ), rType(1, 2, 4, 0, `FN_AND), 0, modeDual,
           useOf(10, 0, 0, 1, 0, 0), useOf(1, 2, 4, 1, 1, 1));
    addRow(2'b11, iType(`OP_REGIMM, 11, `RI_BGEZ), rType(1, 2, 5, 0, `FN_XOR), 0, modeDual,
           useOf(11, 0, 0, 1, 0, 0), useOf(1, 2, 5, 1, 1, 1));
    addRow(2'b11, iType(`OP_REGIMM, 12, `RI_BLTZAL), rType(31, 1, 6, 0, `FN_ADDU), 0,
           modeSingle, useOf(12, 0, 31, 1, 0, 1), useOf(12, 0, 31, 1, 0, 1));
    addRow(2'b11, iType(`OP_REGIMM, 13, `RI_BGEZAL), rType(1, 2, 6, 0, `FN_ADDU), 0,
           modeDual, useOf(13, 0, 31, 1, 0, 1), useOf(1, 2, 6, 1, 1, 1));
    addRow(2'b11, jType(`OP_J), iType(`OP_ORI, 8, 7), 0, modeDual,
           useOf(0, 0, 0, 0, 0, 0), useOf(8, 0, 7, 1, 0, 1));
    addRow(2'b11, {6'h3f, 26'h3ff_ffff}, {6'h3e, 26'h155_5555}, 0, modeDual,
           useOf(0, 0, 0, 0, 0, 0), useOf(0, 0, 0, 0, 0, 0));
    // r0 write still counts as a hazard
    addRow(2'b11, rType(1, 2, 0, 0, `FN_ADDU), rType(0, 3, 4, 0, `FN_ADDU), 0, modeSingle,
           useOf(1, 2, 0, 1, 1, 1), useOf(1, 2, 0, 1, 1, 1));
    addRow(2'b00, rType(1, 2, 3, 0, `FN_ADDU), iType(`OP_ORI, 4, 6), 0, modeNone,
           useOf(1, 2, 3, 1, 1, 1), useOf(4, 0, 6, 1, 0, 1));
    addRow(2'b01, rType(1, 2, 3, 0, `FN_ADDU), iType(`OP_ORI, 4, 6), 0, modeSingle,
           useOf(1, 2, 3, 1, 1, 1), useOf(1, 2, 3, 1, 1, 1));
    addRow(2'b01, iType(`OP_LW, 8, 9), iType(`OP_SW, 9, 9), 0, modeSingle,
           useOf(8, 0, 9, 1, 0, 1), useOf(8, 0, 9, 1, 0, 1));
endtask

`endif

/* verification/issueTb.sv */
`timescale 1ns/1ps
`include "issue_params.svh"

module issueTb;

    localparam issuePkg::issueMode_t modeNone   = issuePkg::noIssue;
    localparam issuePkg::issueMode_t modeSingle = issuePkg::singleIssue;
    localparam issuePkg::issueMode_t modeDual   = issuePkg::dualIssue;

    logic                 clk;
    logic                 rstN;
    logic [1:0]           supplyValid;
    issuePkg::fetchInfo_t entry0;
    issuePkg::fetchInfo_t entry1;
    issuePkg::fetchInfo_t slot0;
    issuePkg::fetchInfo_t slot1;
    issuePkg::issueMode_t issueMode;
    issuePkg::regUse_t    regUse0;
    issuePkg::regUse_t    regUse1;
    issuePkg::fetchInfo_t expFetch0;
    issuePkg::fetchInfo_t expFetch1;
    int                   seed = 32'ha1ef8c59;
    int                   cycleCount = 0;
    int                   timeoutLimit;

    // ------------------------------
    // instruction builders
    function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sh,
                                          input logic [5:0] fn);
        return {`OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt);
        return {op, rs, rt, 16'h1234};
    endfunction

    function automatic logic [31:0] jType(input logic [5:0] op);
        return {op, 26'h0a5_c3f0};
    endfunction

    function automatic issuePkg::regUse_t useOf(input logic [4:0] rs, input logic [4:0] rt,
                                                 input logic [4:0] wr, input logic nRs,
                                                 input logic nRt, input logic nWr);
        return '{rsNum: rs, rtNum: rt, wrNum: wr, needRs: nRs, needRt: nRt, needWr: nWr};
    endfunction

    `include "issueVectors.svh"

    dualIssueArbiter dut0 (
        .clk(clk), .rstN_i(rstN), .supplyValid_i(supplyValid),
        .pcEntry0_i(entry0.pc), .instEntry0_i(entry0.inst), .hasExcEntry0_i(entry0.hasExc),
        .excCodeEntry0_i(entry0.excCode), .predTakeEntry0_i(entry0.predTake),
        .predDestEntry0_i(entry0.predDest),
        .pcEntry1_i(entry1.pc), .instEntry1_i(entry1.inst), .hasExcEntry1_i(entry1.hasExc),
        .excCodeEntry1_i(entry1.excCode), .predTakeEntry1_i(entry1.predTake),
        .predDestEntry1_i(entry1.predDest),
        .issueMode_o(issueMode),
        .pcSlot0_o(slot0.pc), .instSlot0_o(slot0.inst), .hasExcSlot0_o(slot0.hasExc),
        .excCodeSlot0_o(slot0.excCode), .predTakeSlot0_o(slot0.predTake),
        .predDestSlot0_o(slot0.predDest), .regUseSlot0_o(regUse0),
        .pcSlot1_o(slot1.pc), .instSlot1_o(slot1.inst), .hasExcSlot1_o(slot1.hasExc),
        .excCodeSlot1_o(slot1.excCode), .predTakeSlot1_o(slot1.predTake),
        .predDestSlot1_o(slot1.predDest), .regUseSlot1_o(regUse1)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------
    // compare tasks
    task automatic checkMode(input string name, input issuePkg::issueMode_t exp,
                             input issuePkg::issueMode_t act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %s got %s", $time, name, exp.name(), act.name());
            $display("Checks failed");
            $fatal(1, "mismatch, run stopped");
        end
    endtask

    task automatic checkRegUse(input string name, input issuePkg::regUse_t exp,
                               input issuePkg::regUse_t act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %h got %h", $time, name, exp, act);
            $display("Checks failed");
            $fatal(1, "mismatch, run stopped");
        end
    endtask

    task automatic checkFetch(input string name, input issuePkg::fetchInfo_t exp,
                              input issuePkg::fetchInfo_t act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %h got %h", $time, name, exp, act);
            $display("Checks failed");
            $fatal(1, "mismatch, run stopped");
        end
    endtask

    task automatic checkCleared();
        checkMode("issueMode_o", modeNone, issueMode);
        checkRegUse("regUseSlot0_o", '0, regUse0);
        checkRegUse("regUseSlot1_o", '0, regUse1);
        checkFetch("slot 0 fetch payload", '0, slot0);
        checkFetch("slot 1 fetch payload", '0, slot1);
    endtask

    task automatic randomFetch(output issuePkg::fetchInfo_t info);
        logic [31:0] bits;
        info.pc       = $random(seed);
        bits          = $random(seed);
        info.hasExc   = bits[0];
        info.excCode  = bits[5:1];
        info.predTake = bits[6];
        info.predDest = $random(seed);
    endtask

    task automatic driveRow(input int r);
        randomFetch(entry0);
        randomFetch(entry1);
        entry0.inst   = rowInst0[r];
        entry0.hasExc = rowExc0[r];
        entry1.inst   = rowInst1[r];
        supplyValid   = rowValid[r];
        expFetch0     = entry0;
        expFetch1     = (rowMode[r] == modeSingle) ? entry0 : entry1;   // single issue copies
    endtask

    task automatic checkRow(input int r);
        checkMode("issueMode_o", rowMode[r], issueMode);
        checkRegUse("regUseSlot0_o", rowUse0[r], regUse0);
        checkRegUse("regUseSlot1_o", rowUse1[r], regUse1);
        checkFetch("slot 0 fetch payload", expFetch0, slot0);
        checkFetch("slot 1 fetch payload", expFetch1, slot1);
    endtask

    // ------------------------------
    // watchdog
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutLimit) begin
            $display("Timeout after %0d cycles, table did not finish", cycleCount);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rstN         = 1'b0;
        supplyValid  = 2'b00;
        entry0       = '0;
        entry1       = '0;
        expFetch0    = '0;
        expFetch1    = '0;
        loadVectors();
        timeoutLimit = 10 + rowCount + 20;
        repeat (10) begin
            @(negedge clk);
            checkCleared();
        end
        rstN = 1'b1;
        for (int r = 0; r < rowCount; r++) begin
            if (r > 0) begin
                checkRow(r - 1);
            end
            driveRow(r);
            @(negedge clk);
        end
        checkRow(rowCount - 1);
        $display("All checks passed");
        $finish;
    end

endmodule

/* all.f */
+incdir+source
+incdir+verification
source/issuePkg.sv
source/regUseDecoder.sv
source/issueRule.sv
source/slotSteer.sv
source/dualIssueArbiter.sv
verification/issueTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wall -f all.f --top-module issueTb -o issueSim

out=$(./obj_dir/issueSim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
    exit 0
else
    exit 1
fi
